// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int reg_width = 32;
    localparam int reg_count = 16;
    localparam int imm_width = 16;
    localparam int pc_step   = 4;

    typedef logic [reg_width-1:0] t_reg;
    typedef logic [$clog2(reg_count)-1:0] t_reg_index;
    typedef t_reg t_regs [reg_count];

    // Kind of 16-bit immediate write
    typedef enum logic [1:0] {
        IT_BOTTOM   = 2'd0,
        IT_TOP      = 2'd1,
        IT_UNSIGNED = 2'd2,
        IT_SIGNED   = 2'd3
    } t_imm_type;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_LDI  = 4'h6,
        OP_JUMP = 4'h7,
        OP_BZ   = 4'h8
    } t_opcode;

    // For OP_LDI the low two bits of rs2 carry the immediate kind
    typedef struct packed {
        t_opcode                opcode;
        t_reg_index             rd;
        t_reg_index             rs1;
        t_reg_index             rs2;
        logic [imm_width-1:0]   imm;
    } t_instr;

    typedef struct packed {
        logic                   write;
        logic                   write_immediate;
        t_reg_index             index;
        t_reg                   data;
        logic [imm_width-1:0]   imm;
        t_imm_type              imm_type;
    } t_reg_update;

    typedef struct packed {
        logic                   jump;
        logic                   inc;
        logic                   branch;
        t_reg                   jump_target;
        logic [imm_width-1:0]   branch_offset;
    } t_pc_update;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  t_reg_update reg_update,
    input  t_reg_index  read1_index,
    input  t_reg_index  read2_index,
    input  t_reg_index  read3_index,
    output t_reg        read1_data,
    output t_reg        read2_data,
    output t_reg        read3_data
);

    t_regs regs;

    // Reads straight from state, so the next instruction sees this edge's write
    assign read1_data = regs[read1_index];
    assign read2_data = regs[read2_index];
    assign read3_data = regs[read3_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_update.write) begin
            regs[reg_update.index] <= reg_update.data;
        end else if (reg_update.write_immediate) begin
            case (reg_update.imm_type)
                IT_BOTTOM: begin
                    regs[reg_update.index][imm_width-1:0] <= reg_update.imm;
                end
                IT_TOP: begin
                    regs[reg_update.index][reg_width-1:imm_width] <= reg_update.imm;
                end
                IT_UNSIGNED: begin
                    regs[reg_update.index] <= {{(reg_width-imm_width){1'b0}}, reg_update.imm};
                end
                IT_SIGNED: begin
                    regs[reg_update.index] <=
                        {{(reg_width-imm_width){reg_update.imm[imm_width-1]}}, reg_update.imm};
                end
            endcase
        end
    end

endmodule

// File: logic/program_counter.sv
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  t_pc_update pc_update,
    output t_reg       pc
);

    t_reg pc_q;
    t_reg branch_offset_ext;

    assign pc = pc_q;

    // Signed 16-bit offset widened to a full word
    assign branch_offset_ext = {
        {(reg_width-imm_width){pc_update.branch_offset[imm_width-1]}},
        pc_update.branch_offset
    };

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_q <= '0;
        end else if (pc_update.jump) begin
            pc_q <= pc_update.jump_target;
        end else if (pc_update.inc) begin
            pc_q <= pc_q + t_reg'(pc_step);
        end else if (pc_update.branch) begin
            pc_q <= pc_q + branch_offset_ext;
        end
    end

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
    input  t_instr      instr,
    input  logic        instr_valid,
    input  t_reg        rs1_data,
    input  t_reg        rs2_data,
    output t_reg_update reg_update,
    output t_pc_update  pc_update
);

    t_reg alu_result;
    logic rs1_zero;

    assign rs1_zero = (rs1_data == '0);

    // ALU that wraps at 32 bits
    always_comb begin
        case (instr.opcode)
            OP_ADD: begin
                alu_result = rs1_data + rs2_data;
            end
            OP_SUB: begin
                alu_result = rs1_data - rs2_data;
            end
            OP_AND: begin
                alu_result = rs1_data & rs2_data;
            end
            OP_OR: begin
                alu_result = rs1_data | rs2_data;
            end
            OP_XOR: begin
                alu_result = rs1_data ^ rs2_data;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    always_comb begin
        reg_update = '0;
        pc_update  = '0;

        if (instr_valid) begin
            case (instr.opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    reg_update.write = 1'b1;
                    reg_update.index = instr.rd;
                    reg_update.data  = alu_result;
                    pc_update.inc    = 1'b1;
                end
                OP_LDI: begin
                    reg_update.write_immediate = 1'b1;
                    reg_update.index           = instr.rd;
                    reg_update.imm             = instr.imm;
                    reg_update.imm_type        = t_imm_type'(instr.rs2[1:0]);
                    pc_update.inc              = 1'b1;
                end
                OP_JUMP: begin
                    pc_update.jump        = 1'b1;
                    pc_update.jump_target = rs1_data;
                end
                OP_BZ: begin
                    // Taken branch adds the offset, otherwise fall through
                    if (rs1_zero) begin
                        pc_update.branch        = 1'b1;
                        pc_update.branch_offset = instr.imm;
                    end else begin
                        pc_update.inc = 1'b1;
                    end
                end
                default: begin
                    // NOP and unused encodings just step
                    pc_update.inc = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: logic/exec_core.sv
`timescale 1ns/1ps

module exec_core import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  t_instr     instr,
    input  logic       instr_valid,
    input  t_reg_index dbg_index,
    output t_reg       dbg_data,
    output t_reg       pc
);

    t_reg        rs1_data;
    t_reg        rs2_data;
    t_reg_update reg_update;
    t_pc_update  pc_update;

    register_file u_register_file (
        .clock       (clock),
        .reset       (reset),
        .reg_update  (reg_update),
        .read1_index (instr.rs1),
        .read2_index (instr.rs2),
        .read3_index (dbg_index),
        .read1_data  (rs1_data),
        .read2_data  (rs2_data),
        .read3_data  (dbg_data)
    );

    program_counter u_program_counter (
        .clock     (clock),
        .reset     (reset),
        .pc_update (pc_update),
        .pc        (pc)
    );

    execute_unit u_execute_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .reg_update  (reg_update),
        .pc_update   (pc_update)
    );

endmodule

// File: dv/exec_core_chk.sv
`timescale 1ns/1ps

module exec_core_chk import cpu_pkg::*; (
    input logic   clock,
    input logic   reset,
    input t_instr instr,
    input logic   instr_valid,
    input t_reg   pc
);

    logic        alu_or_ldi;
    int unsigned fail_count = 0;

    assign alu_or_ldi = instr_valid &&
        (instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI});

    pc_zero_in_reset: assert property (@(posedge clock) reset |-> pc == '0)
        else begin
            $error("pc is not zero while reset is high");
            fail_count++;
        end

    // Idle cycle leaves pc alone
    pc_hold_when_idle: assert property (
        @(posedge clock) disable iff (reset) !instr_valid |=> $stable(pc)
    ) else begin
        $error("pc changed across a cycle without an instruction");
        fail_count++;
    end

    pc_step_after_alu: assert property (
        @(posedge clock) disable iff (reset)
        alu_or_ldi |=> pc == $past(pc) + t_reg'(pc_step)
    ) else begin
        $error("pc did not advance by 4 after an ALU or LDI instruction");
        fail_count++;
    end

endmodule

bind exec_core exec_core_chk u_exec_core_chk (
    .clock       (clock),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .pc          (pc)
);

// File: dv/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb import cpu_pkg::*; ();

    logic       clock;
    logic       reset;
    t_instr     instr;
    logic       instr_valid;
    t_reg_index dbg_index;
    t_reg       dbg_data;
    t_reg       pc;

    typedef struct packed {
        t_instr     instr;
        logic       valid;
        t_reg_index dbg_index;
        t_reg       exp_reg;
        t_reg       exp_pc;
    } t_row;

    t_row        rows [$];
    t_regs       model_regs;
    t_reg        model_pc;
    logic [31:0] seed;
    logic        reset_ok;
    int          error_count;
    int          steps;

    exec_core UUT (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dbg_index   (dbg_index),
        .dbg_data    (dbg_data),
        .pc          (pc)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic t_instr make_instr(input t_opcode op, input t_reg_index rd,
                                          input t_reg_index rs1, input t_reg_index rs2,
                                          input logic [15:0] imm);
        t_instr ins;
        ins.opcode = op;
        ins.rd     = rd;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.imm    = imm;
        return ins;
    endfunction

    task automatic add_row(input t_opcode op, input t_reg_index rd, input t_reg_index rs1,
                           input t_reg_index rs2, input logic [15:0] imm, input logic valid,
                           input t_reg_index dbg, input t_reg exp_reg, input t_reg exp_pc);
        t_row row;
        row.instr     = make_instr(op, rd, rs1, rs2, imm);
        row.valid     = valid;
        row.dbg_index = dbg;
        row.exp_reg   = exp_reg;
        row.exp_pc    = exp_pc;
        rows.push_back(row);
    endtask

    task automatic report_mismatch(input string what, input int step,
                                   input t_reg expected, input t_reg got);
        error_count++;
        $display("ERROR at %0t ns: %s at step %0d, expected %08h, got %08h",
                 $time, what, step, expected, got);
    endtask

    task automatic build_table();
        // Immediate kinds selected by the low bits of rs2
        add_row(OP_LDI, 4'd1, 4'd0, 4'd3, 16'h8001, 1'b1, 4'd1, 32'hFFFF8001, 32'h00000004);
        add_row(OP_LDI, 4'd1, 4'd0, 4'd1, 16'h1234, 1'b1, 4'd1, 32'h12348001, 32'h00000008);
        add_row(OP_LDI, 4'd2, 4'd0, 4'd2, 16'h8001, 1'b1, 4'd2, 32'h00008001, 32'h0000000C);
        add_row(OP_LDI, 4'd2, 4'd0, 4'd0, 16'hABCD, 1'b1, 4'd2, 32'h0000ABCD, 32'h00000010);
        add_row(OP_LDI, 4'd3, 4'd0, 4'd3, 16'h8000, 1'b1, 4'd3, 32'hFFFF8000, 32'h00000014);
        add_row(OP_LDI, 4'd3, 4'd0, 4'd0, 16'hFFFF, 1'b1, 4'd3, 32'hFFFFFFFF, 32'h00000018);
        // ALU chain where each step reads the previous result
        add_row(OP_ADD, 4'd4, 4'd3, 4'd2, 16'h0000, 1'b1, 4'd4, 32'h0000ABCC, 32'h0000001C);
        add_row(OP_SUB, 4'd5, 4'd2, 4'd1, 16'h0000, 1'b1, 4'd5, 32'hEDCC2BCC, 32'h00000020);
        add_row(OP_AND, 4'd6, 4'd5, 4'd2, 16'h0000, 1'b1, 4'd6, 32'h00002BCC, 32'h00000024);
        add_row(OP_OR,  4'd7, 4'd6, 4'd1, 16'h0000, 1'b1, 4'd7, 32'h1234ABCD, 32'h00000028);
        add_row(OP_XOR, 4'd8, 4'd7, 4'd2, 16'h0000, 1'b1, 4'd8, 32'h12340000, 32'h0000002C);
        // Branches taken forward and back, then not taken
        add_row(OP_BZ,  4'd0, 4'd0, 4'd0, 16'h0010, 1'b1, 4'd8, 32'h12340000, 32'h0000003C);
        add_row(OP_BZ,  4'd0, 4'd0, 4'd0, 16'hFFF8, 1'b1, 4'd4, 32'h0000ABCC, 32'h00000034);
        add_row(OP_BZ,  4'd0, 4'd8, 4'd0, 16'h0100, 1'b1, 4'd5, 32'hEDCC2BCC, 32'h00000038);
        add_row(OP_ADD, 4'd9, 4'd7, 4'd7, 16'h0000, 1'b0, 4'd9, 32'h00000000, 32'h00000038);
        add_row(OP_LDI, 4'd9, 4'd0, 4'd2, 16'h0200, 1'b1, 4'd9, 32'h00000200, 32'h0000003C);
        add_row(OP_JUMP, 4'd0, 4'd9, 4'd0, 16'h0000, 1'b1, 4'd9, 32'h00000200, 32'h00000200);
        add_row(OP_NOP, 4'd0, 4'd0, 4'd0, 16'h0000, 1'b1, 4'd0, 32'h00000000, 32'h00000204);
    endtask

    task automatic apply_reset(output logic cleared);
        int waited;
        waited = 0;
        instr_valid = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        while (pc !== '0 && waited < 20) begin
            @(posedge clock);
            #1;
            waited++;
        end
        cleared = (pc === '0);
    endtask

    task automatic check_reset_state();
        if (pc !== '0) report_mismatch("pc after reset", 0, '0, pc);
        for (int r = 0; r < reg_count; r++) begin
            dbg_index = t_reg_index'(r);
            #1;
            if (dbg_data !== '0) report_mismatch("register after reset", r, '0, dbg_data);
            @(posedge clock);
            #1;
        end
    endtask

    task automatic run_table();
        for (int i = 0; i < rows.size(); i++) begin
            instr       = rows[i].instr;
            instr_valid = rows[i].valid;
            dbg_index   = rows[i].dbg_index;
            @(posedge clock);
            #1;
            if (dbg_data !== rows[i].exp_reg) begin
                report_mismatch("register", i, rows[i].exp_reg, dbg_data);
            end
            if (pc !== rows[i].exp_pc) report_mismatch("pc", i, rows[i].exp_pc, pc);
            steps++;
        end
        instr_valid = 1'b0;
    endtask

    task automatic run_random(input int count);
        t_instr  ins;
        t_opcode op;
        t_reg    a;
        t_reg    b;
        t_reg    old;
        t_reg    result;
        int      pick;
        for (int r = 0; r < reg_count; r++) begin
            model_regs[r] = '0;
        end
        model_pc = '0;
        for (int n = 0; n < count; n++) begin
            seed = lcg_next(seed);
            pick = seed[31:16] % 6;
            case (pick)
                0: op = OP_ADD;
                1: op = OP_SUB;
                2: op = OP_AND;
                3: op = OP_OR;
                4: op = OP_XOR;
                default: op = OP_LDI;
            endcase
            seed = lcg_next(seed);
            ins = make_instr(op, seed[31:28], seed[27:24], seed[23:20], seed[19:4]);

            // Shadow model of the execution rules
            a   = model_regs[ins.rs1];
            b   = model_regs[ins.rs2];
            old = model_regs[ins.rd];
            case (ins.opcode)
                OP_ADD: result = a + b;
                OP_SUB: result = a - b;
                OP_AND: result = a & b;
                OP_OR:  result = a | b;
                OP_XOR: result = a ^ b;
                default: begin
                    case (t_imm_type'(ins.rs2[1:0]))
                        IT_BOTTOM:   result = {old[31:16], ins.imm};
                        IT_TOP:      result = {ins.imm, old[15:0]};
                        IT_UNSIGNED: result = {16'h0000, ins.imm};
                        default:     result = {{16{ins.imm[15]}}, ins.imm};
                    endcase
                end
            endcase

            instr       = ins;
            instr_valid = 1'b1;
            dbg_index   = ins.rd;
            @(posedge clock);
            #1;
            model_regs[ins.rd] = result;
            model_pc = model_pc + 32'd4;
            if (dbg_data !== result) report_mismatch("random register", n, result, dbg_data);
            if (pc !== model_pc) report_mismatch("random pc", n, model_pc, pc);
            steps++;
        end
        instr_valid = 1'b0;
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        dbg_index   = '0;
        error_count = 0;
        steps       = 0;
        seed        = 32'd77160;
        reset_ok    = 1'b0;
        build_table();
        apply_reset(reset_ok);
        if (reset_ok) begin
            check_reset_state();
            run_table();
            apply_reset(reset_ok);
            if (reset_ok) begin
                check_reset_state();
                run_random(40);
            end
        end
        if (!reset_ok) begin
            $display("Timeout: pc did not return to zero within 20 cycles after reset");
        end
        $display("Steps checked: %0d, errors: %0d, assertion failures: %0d",
                 steps, error_count, UUT.u_exec_core_chk.fail_count);
        if (reset_ok && error_count == 0 && UUT.u_exec_core_chk.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: exec_core.f
logic/cpu_pkg.sv
logic/register_file.sv
logic/program_counter.sv
logic/execute_unit.sv
logic/exec_core.sv
dv/exec_core_chk.sv
dv/exec_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = exec_core_tb
FILELIST  = exec_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
